//--- clock_top.f
hw/clock_pkg.sv
hw/tick_gen.sv
hw/time_counter.sv
hw/led_encoder.sv
hw/clock_top.sv
sim/clock_asserts.sv
sim/clock_tb.sv

//--- Makefile
TOP := clock_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f clock_top.f -Mdir obj_dir -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

//--- sim/clock_tb.sv
`timescale 1ns/1ps

module clock_tb
    import clock_pkg::*;
();

    localparam int sec_cycles   = scan_div * scan_per_sec;
    localparam int guard_cycles = 10000;         // Stay this far from a second boundary
    localparam int dig_timeout  = 8 * scan_div;

    logic      clk;
    logic      rst;
    logic      load;
    bcd_time_t load_time;
    logic      inc_min;
    logic      inc_hour;
    seg_t      seg;
    dig_t      dig;

    int cyc;       // Rising edges since reset release
    int errors;
    int timeouts;

    clock_top UUT (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .load_time (load_time),
        .inc_min   (inc_min),
        .inc_hour  (inc_hour),
        .seg       (seg),
        .dig       (dig)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // Reference segment table, gfedcba active low
    function automatic seg_t seg_pattern(input logic [3:0] h);
        case (h)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    function automatic int hex_of_seg(input seg_t s);
        for (int i = 0; i < 16; i++) begin
            if (seg_pattern(4'(i)) == s) begin
                return i;
            end
        end
        return -1;  // Not a digit shape
    endfunction

    function automatic bit in_window();
        int phase;
        phase = cyc % sec_cycles;
        return (phase >= guard_cycles) && (phase <= sec_cycles - 4 * guard_cycles);
    endfunction

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_dig(input string name, input dig_t exp, input dig_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_time(input string name, input bcd_time_t exp, input bcd_time_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_for_dig(input dig_t target);
        int n;
        n = 0;
        while (dig !== target && n < dig_timeout) begin
            @(negedge clk);
            n++;
        end
        if (dig !== target) begin
            $display("Timeout: digit select never reached %b", target);
            timeouts++;
        end
    endtask

    task automatic skip_boundary();
        int n;
        n = 0;
        while (!in_window() && n < sec_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!in_window()) begin
            $display("Timeout: no quiet stretch away from the second boundary");
            timeouts++;
        end
    endtask

    task automatic wait_seconds(input int count);
        int target;
        int n;
        target = (cyc / sec_cycles + count) * sec_cycles + guard_cycles;
        n = 0;
        while (cyc < target && n < (count + 1) * sec_cycles) begin
            @(negedge clk);
            n++;
        end
        if (cyc < target) begin
            $display("Timeout: second boundaries did not arrive");
            timeouts++;
        end
    endtask

    // Walks dig through each position and decodes the lit digit
    task automatic read_display(output bcd_time_t shown);
        int h;
        shown = '0;
        @(negedge clk);
        for (int n = 0; n < num_digits; n++) begin
            wait_for_dig(dig_t'(1) << n);
            h = hex_of_seg(seg);
            if (h < 0) begin
                $display("Digit %0d shows segment pattern %b, which is no known digit", n, seg);
                errors++;
            end else begin
                shown[4*n +: 4] = 4'(h);
            end
        end
    endtask

    task automatic load_value(input bcd_time_t t, input logic with_min);
        @(negedge clk);
        load      = 1'b1;
        load_time = t;
        inc_min   = with_min;
        @(negedge clk);
        load    = 1'b0;
        inc_min = 1'b0;
    endtask

    task automatic pulse_min();
        @(negedge clk);
        inc_min = 1'b1;
        @(negedge clk);
        inc_min = 1'b0;
    endtask

    task automatic pulse_hour();
        @(negedge clk);
        inc_hour = 1'b1;
        @(negedge clk);
        inc_hour = 1'b0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_dig("reset dig", '0, dig);
        check_seg("reset seg", seg_blank, seg);
        rst = 1'b0;
        @(negedge clk);
        check_dig("first digit select", dig_t'(1), dig);
        check_seg("first digit seg", seg_pattern(4'h0), seg);
    endtask

    task automatic test_scan_order();
        dig_t cur;
        int   len;
        wait_for_dig(dig_t'(2));  // First scan tick moved to digit 1
        cur = dig_t'(2);
        for (int step = 0; step < num_digits; step++) begin
            len = 0;
            while (dig === cur && len <= 2 * scan_div) begin
                @(negedge clk);
                len++;
            end
            check_count("scan hold time", scan_div, len);
            cur = (cur == dig_t'(1 << (num_digits - 1))) ? dig_t'(1) : cur << 1;
            check_dig("scan order", cur, dig);
        end
    endtask

    task automatic test_load_display();
        bcd_time_t shown;
        skip_boundary();
        load_value(24'h123456, 1'b0);
        read_display(shown);
        check_time("load 12:34:56", 24'h123456, shown);
        load_value(24'hfedcba, 1'b0);
        read_display(shown);
        check_time("load hex FEDCBA", 24'hfedcba, shown);
    endtask

    task automatic test_rollover();
        bcd_time_t shown;
        skip_boundary();
        load_value(24'h235959, 1'b0);
        wait_seconds(1);
        read_display(shown);
        check_time("day rollover", 24'h000000, shown);
        skip_boundary();
        load_value(24'h095958, 1'b0);
        wait_seconds(2);
        read_display(shown);
        check_time("hour carry", 24'h100000, shown);
    endtask

    task automatic test_set_controls();
        bcd_time_t shown;
        skip_boundary();
        load_value(24'h105930, 1'b0);
        pulse_min();
        read_display(shown);
        check_time("inc_min wrap", 24'h100030, shown);
        skip_boundary();
        load_value(24'h231500, 1'b0);
        pulse_hour();
        read_display(shown);
        check_time("inc_hour wrap", 24'h001500, shown);
        skip_boundary();
        load_value(24'h083000, 1'b1);  // Load wins over inc_min
        read_display(shown);
        check_time("load with inc_min", 24'h083000, shown);
    endtask

    task automatic test_quiet();
        bcd_time_t shown;
        skip_boundary();
        load_value(24'h074512, 1'b0);
        read_display(shown);
        check_time("quiet first read", 24'h074512, shown);
        read_display(shown);
        check_time("quiet second read", 24'h074512, shown);
    endtask

    initial begin
        rst       = 1'b1;
        load      = 1'b0;
        load_time = '0;
        inc_min   = 1'b0;
        inc_hour  = 1'b0;
        errors    = 0;
        timeouts  = 0;
        repeat (16) @(posedge clk);
        test_reset();
        test_scan_order();
        test_load_display();
        test_rollover();
        test_set_controls();
        test_quiet();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/clock_asserts.sv
`timescale 1ns/1ps

module clock_asserts
    import clock_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic scan_tick,
    input seg_t seg,
    input dig_t dig
);

    // At most one digit lit
    a_dig_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dig))
        else $error("Digit select is not one-hot: %b", dig);

    // Index steps on scan_tick, dig register follows a cycle later
    a_dig_step: assert property (@(posedge clk) disable iff (rst)
        ($changed(dig) && $past(dig) != '0) |-> $past(scan_tick, 2))
        else $error("Digit select moved without a scan tick");

    a_reset_dark: assert property (@(posedge clk) (rst && seg == seg_blank) |-> dig == '0)
        else $error("Digit select active while blanked in reset");

endmodule

bind led_encoder clock_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .scan_tick (scan_tick),
    .seg       (seg),
    .dig       (dig)
);

//--- hw/clock_top.sv
`timescale 1ns/1ps

module clock_top
    import clock_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  bcd_time_t load_time,
    input  logic      inc_min,
    input  logic      inc_hour,
    output seg_t      seg,
    output dig_t      dig
);

    logic      scan_tick;
    logic      sec_tick;
    bcd_time_t time_bcd;

    tick_gen u_tick_gen (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .sec_tick  (sec_tick)
    );

    time_counter u_time_counter (
        .clk       (clk),
        .rst       (rst),
        .sec_tick  (sec_tick),
        .load      (load),
        .load_time (load_time),
        .inc_min   (inc_min),
        .inc_hour  (inc_hour),
        .time_bcd  (time_bcd)
    );

    led_encoder u_led_encoder (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .time_bcd  (time_bcd),
        .seg       (seg),
        .dig       (dig)
    );

endmodule

//--- hw/led_encoder.sv
`timescale 1ns/1ps

module led_encoder
    import clock_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      scan_tick,
    input  bcd_time_t time_bcd,
    output seg_t      seg,
    output dig_t      dig
);

    localparam int idx_w = $clog2(num_digits);

    logic [idx_w-1:0] idx;      // Digit being shown
    logic             idx_last;
    logic [3:0]       nibble;

    assign idx_last = (idx == idx_w'(num_digits - 1));
    assign nibble   = time_bcd[4*idx +: 4];

    // Digit index walks 0..5 on the scan tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx <= '0;
        end else if (scan_tick) begin
            if (idx_last) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Outputs re-registered every cycle so time changes show up at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg <= seg_blank;  // Dark while in reset
            dig <= '0;
        end else begin
            seg <= seg_of_hex(nibble);
            dig <= dig_t'(1) << idx;  // One-hot select
        end
    end

endmodule

//--- hw/time_counter.sv
`timescale 1ns/1ps

module time_counter
    import clock_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      sec_tick,
    input  logic      load,
    input  bcd_time_t load_time,
    input  logic      inc_min,
    input  logic      inc_hour,
    output bcd_time_t time_bcd
);

    logic [3:0] sec_ones;
    logic [3:0] sec_tens;
    logic [3:0] min_ones;
    logic [3:0] min_tens;
    logic [3:0] hour_ones;
    logic [3:0] hour_tens;

    // Carry out of each digit when it advances
    logic       sec_ones_c;
    logic       sec_tens_c;
    logic       min_ones_c;
    logic       min_tens_c;
    logic       hour_ones_c;
    logic [3:0] hour_ones_lim;

    // Next values for one field advance, no carry out of the field
    logic [3:0] min_ones_nxt;
    logic [3:0] min_tens_nxt;
    logic [3:0] hour_ones_nxt;
    logic [3:0] hour_tens_nxt;

    // Digit at or above its limit goes back to zero
    function automatic logic [3:0] bcd_step(input logic [3:0] d, input logic [3:0] lim);
        if (d >= lim) begin
            return 4'd0;
        end
        return d + 4'd1;
    endfunction

    assign hour_ones_lim = (hour_tens >= 4'd2) ? 4'd3 : 4'd9;  // 20..23 stop at 3

    assign sec_ones_c  = (sec_ones >= 4'd9);
    assign sec_tens_c  = (sec_tens >= 4'd5);
    assign min_ones_c  = (min_ones >= 4'd9);
    assign min_tens_c  = (min_tens >= 4'd5);
    assign hour_ones_c = (hour_ones >= hour_ones_lim);

    always_comb begin
        min_ones_nxt = bcd_step(min_ones, 4'd9);
        min_tens_nxt = min_tens;
        if (min_ones_c) begin
            min_tens_nxt = bcd_step(min_tens, 4'd5);  // 59 -> 00
        end
    end

    always_comb begin
        hour_ones_nxt = bcd_step(hour_ones, hour_ones_lim);
        hour_tens_nxt = hour_tens;
        if (hour_ones_c) begin
            hour_tens_nxt = bcd_step(hour_tens, 4'd2);  // 23 -> 00
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sec_ones  <= 4'd0;
            sec_tens  <= 4'd0;
            min_ones  <= 4'd0;
            min_tens  <= 4'd0;
            hour_ones <= 4'd0;
            hour_tens <= 4'd0;
        end else if (load) begin
            // Taken as given, no range check
            {hour_tens, hour_ones, min_tens, min_ones, sec_tens, sec_ones} <= load_time;
        end else if (inc_hour) begin
            hour_ones <= hour_ones_nxt;
            hour_tens <= hour_tens_nxt;
        end else if (inc_min) begin
            min_ones <= min_ones_nxt;  // Hours left alone
            min_tens <= min_tens_nxt;
        end else if (sec_tick) begin
            sec_ones <= bcd_step(sec_ones, 4'd9);
            if (sec_ones_c) begin
                sec_tens <= bcd_step(sec_tens, 4'd5);
                if (sec_tens_c) begin
                    min_ones <= min_ones_nxt;
                    min_tens <= min_tens_nxt;
                    if (min_ones_c && min_tens_c) begin
                        hour_ones <= hour_ones_nxt;  // Full hour rollover
                        hour_tens <= hour_tens_nxt;
                    end
                end
            end
        end
    end

    assign time_bcd = {hour_tens, hour_ones, min_tens, min_ones, sec_tens, sec_ones};

endmodule

//--- hw/tick_gen.sv
`timescale 1ns/1ps

module tick_gen
    import clock_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic scan_tick,
    output logic sec_tick
);

    logic [$clog2(scan_div)-1:0]     div_cnt;  // Cycles within one scan period
    logic [$clog2(scan_per_sec)-1:0] scan_cnt; // Scan ticks within one second
    logic                            div_last;
    logic                            scan_last;

    assign div_last  = (div_cnt == $bits(div_cnt)'(scan_div - 1));
    assign scan_last = (scan_cnt == $bits(scan_cnt)'(scan_per_sec - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt   <= '0;
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end else begin
            scan_tick <= div_last;              // Registered, lands on cycle scan_div
            sec_tick  <= div_last && scan_last; // Rides on the last scan tick of a second
            if (div_last) begin
                div_cnt <= '0;
                if (scan_last) begin
                    scan_cnt <= '0;
                end else begin
                    scan_cnt <= scan_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/clock_pkg.sv
package clock_pkg;

    localparam int num_digits   = 6;     // Display positions, seconds ones at 0
    localparam int scan_div     = 1000;  // 1 MHz clk, 1 ms per digit
    localparam int scan_per_sec = 1000;  // Scan ticks per second

    // hh:mm:ss as six BCD nibbles, hours tens in the top nibble
    typedef logic [4*num_digits-1:0] bcd_time_t;

    typedef logic [6:0] seg_t;             // gfedcba, active low
    typedef logic [num_digits-1:0] dig_t;  // One-hot, active high

    localparam seg_t seg_blank = 7'b1111111;  // All segments off

    function automatic seg_t seg_of_hex(input logic [3:0] hex);
        case (hex)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;  // A
            4'hb: return 7'b0000011;  // b
            4'hc: return 7'b1000110;  // C
            4'hd: return 7'b0100001;  // d
            4'he: return 7'b0000110;  // E
            default: return 7'b0001110;  // F
        endcase
    endfunction

endpackage
